/* hdl/ahb_pkg.sv */
package ahb_pkg;

  // ========================================
  // transfer control encodings
  // ========================================

  // htrans, AHB-Lite encoding
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // hsize, byte up to 1024-bit line
  typedef enum logic [2:0]
  {
    BYTE            = 3'b000,
    HALFWORD        = 3'b001,
    WORD            = 3'b010,
    DOUBLEWORD      = 3'b011,
    FOURWORDLINE    = 3'b100,
    EIGHTWORDLINE   = 3'b101,
    SIXTEENWORDLINE = 3'b110,
    THIRTY2WORDLINE = 3'b111
  } hsize_t;

  // hburst, INCR is the unlimited kind
  typedef enum logic [2:0]
  {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // ========================================
  // address phase
  // ========================================

  // 1 KB page view of the address
  typedef struct packed
  {
    logic [21:0] page;
    logic [9:0]  offset;
  } ahb_page_addr_t;

  // raw for range compares, fields for boundary test
  typedef union packed
  {
    logic [31:0]    raw;
    ahb_page_addr_t fields;
  } ahb_addr_u;

  // everything the master drives in one address phase
  typedef struct packed
  {
    ahb_addr_u haddr;
    htrans_t   htrans;
    hsize_t    hsize;
    hburst_t   hburst;
  } ahb_addr_phase_t;

endpackage

/* hdl/dec_map_pkg.sv */
package dec_map_pkg;

  // ========================================
  // slave address map
  // ========================================

  // fixed by the map table below
  localparam int unsigned slave_num = 3;

  // inclusive bounds
  typedef struct packed
  {
    logic [31:0] low;
    logic [31:0] high;
  } region_t;

  // one entry per slave, index is the hsel bit
  localparam region_t slave_map [0:slave_num-1] = '{
    // slave 0, first 1 KB
    '{low: 32'h0000_0000, high: 32'h0000_03FF},
    // slave 1
    '{low: 32'h0000_1000, high: 32'h0000_13FF},
    // slave 2
    '{low: 32'h0000_2400, high: 32'h0000_27FF}
  };

  // ========================================
  // decoder state
  // ========================================

  typedef enum logic [1:0]
  {
    DEC_IDLE   = 2'b00,
    DEC_SLVSEL = 2'b01,
    DEC_ERROR  = 2'b10
  } dec_state_t;

endpackage

/* hdl/ahb_addr_match.sv */
`timescale 1ns/100ps

module ahb_addr_match
  import ahb_pkg::*;
  import dec_map_pkg::*;
(
  input  ahb_addr_phase_t      addr_phase,
  output logic [slave_num-1:0] hit,
  output logic                 unmapped,
  output logic                 page_start
);

  // ========================================
  // region compare
  // ========================================

  logic [31:0] addr_raw;

  // full address view
  assign addr_raw = addr_phase.haddr.raw;

  // one comparator pair per slave
  genvar i;
  generate
    for (i = 0; i < slave_num; i++)
    begin : g_region
      always_comb
      begin
        hit[i] = 1'b0;
        // both bounds inclusive
        if ((addr_raw >= slave_map[i].low) && (addr_raw <= slave_map[i].high))
        begin
          hit[i] = 1'b1;
        end
      end
    end
  endgenerate

  // nothing matched, default slave takes it
  assign unmapped = ~|hit;

  // ========================================
  // 1 KB boundary
  // ========================================

  // offset of zero means this beat opens a new page
  // only meaningful on SEQ, FSM qualifies it
  assign page_start = (addr_phase.haddr.fields.offset == 10'd0);

endmodule

/* hdl/beat_counter.sv */
`timescale 1ns/100ps

module beat_counter
  import ahb_pkg::*;
(
  input  logic            hclk,
  input  logic            hreset_n,
  input  logic            hready,
  input  ahb_addr_phase_t addr_phase,
  output logic            burst_over
);

  logic [3:0] count;
  logic       unlimited;
  logic       accept;

  // same qualification as the FSM
  assign accept = hready && (addr_phase.htrans != BUSY);

  always_ff @(posedge hclk, negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      count     <= 4'd0;
      unlimited <= 1'b0;
    end
    else if (accept)
    begin
      if (addr_phase.htrans == NONSEQ)
      begin
        // remaining beats after this first one
        unique case (addr_phase.hburst)
          WRAP4, INCR4:   count <= 4'd3;
          WRAP8, INCR8:   count <= 4'd7;
          WRAP16, INCR16: count <= 4'd15;
          default:        count <= 4'd0;
        endcase
        unlimited <= (addr_phase.hburst == INCR);
      end
      else if ((addr_phase.htrans == SEQ) && (count != 4'd0))
      begin
        // saturate at zero, overrun flagged below
        count <= count - 4'd1;
      end
    end
  end

  // SEQ with nothing left on a fixed-length burst
  assign burst_over = (addr_phase.htrans == SEQ) && (count == 4'd0) && !unlimited;

endmodule

/* hdl/dec_fsm.sv */
`timescale 1ns/100ps

module dec_fsm
  import ahb_pkg::*;
  import dec_map_pkg::*;
(
  input  logic                 hclk,
  input  logic                 hreset_n,
  input  logic                 hready,
  input  ahb_addr_phase_t      addr_phase,
  input  logic [slave_num-1:0] hit,
  input  logic                 unmapped,
  input  logic                 page_start,
  input  logic                 burst_over,
  output logic                 load_sel,
  output logic [slave_num-1:0] load_hit,
  output logic                 err_sel
);

  dec_state_t state;
  dec_state_t state_nxt;
  logic       accept;
  logic       seq_hold;

  // ========================================
  // acceptance
  // ========================================

  // hready low or BUSY, everything holds
  assign accept = hready && (addr_phase.htrans != BUSY);

  // ========================================
  // next state
  // ========================================

  always_comb
  begin
    state_nxt = state;
    if (accept)
    begin
      unique case (addr_phase.htrans)
        IDLE:
        begin
          state_nxt = DEC_IDLE;
        end
        NONSEQ:
        begin
          // new transfer, decide from the map
          state_nxt = unmapped ? DEC_ERROR : DEC_SLVSEL;
        end
        SEQ:
        begin
          // burst continues only from a valid select
          if ((state == DEC_SLVSEL) && !burst_over && !page_start)
          begin
            state_nxt = DEC_SLVSEL;
          end
          else
          begin
            // overrun, page crossing, or SEQ without NONSEQ
            state_nxt = DEC_ERROR;
          end
        end
        default:
        begin
          state_nxt = state;
        end
      endcase
    end
  end

  always_ff @(posedge hclk, negedge hreset_n)
  begin
    if (!hreset_n)
      state <= DEC_IDLE;
    else
      state <= state_nxt;
  end

  // ========================================
  // select register control
  // ========================================

  // SEQ that keeps its state keeps the latched select
  assign seq_hold = (addr_phase.htrans == SEQ) && (state_nxt == state);

  assign load_sel = accept && !seq_hold;
  // only a NONSEQ can enter SLVSEL, so hit is that transfer's slave
  assign load_hit = (state_nxt == DEC_SLVSEL) ? hit : '0;
  assign err_sel  = (state_nxt == DEC_ERROR);

endmodule

/* hdl/sel_register.sv */
`timescale 1ns/100ps

module sel_register
  import dec_map_pkg::*;
#(
  parameter bit out_reg = 1'b1
)
(
  input  logic                 hclk,
  input  logic                 hreset_n,
  input  logic                 load_sel,
  input  logic [slave_num-1:0] load_hit,
  input  logic                 err_sel,
  output logic [slave_num-1:0] hsel,
  output logic                 default_slv_sel
);

  // decoded outputs as one bundle
  typedef struct packed
  {
    logic [slave_num-1:0] hsel;
    logic                 dflt;
  } sel_out_t;

  dec_state_t           mode_q;
  logic [slave_num-1:0] sel_q;
  sel_out_t             sel_out;

  // mode mirrors the FSM state it was told to enter
  always_ff @(posedge hclk, negedge hreset_n)
  begin
    if (!hreset_n)
      mode_q <= DEC_IDLE;
    else if (load_sel)
      mode_q <= err_sel ? DEC_ERROR : ((|load_hit) ? DEC_SLVSEL : DEC_IDLE);
  end

  // latched one-hot, only visible in SLVSEL
  always_ff @(posedge hclk)
  begin
    if (load_sel)
      sel_q <= load_hit;
  end

  assign sel_out.hsel = (mode_q == DEC_SLVSEL) ? sel_q : '0;
  assign sel_out.dflt = (mode_q == DEC_ERROR);

  // ========================================
  // optional output retiming
  // ========================================

  generate
    if (out_reg)
    begin : g_out_ff
      sel_out_t out_q;

      // glitch-free outputs, one extra cycle
      always_ff @(posedge hclk, negedge hreset_n)
      begin
        if (!hreset_n)
          out_q <= '0;
        else
          out_q <= sel_out;
      end

      assign hsel            = out_q.hsel;
      assign default_slv_sel = out_q.dflt;
    end
    else
    begin : g_out_comb
      assign hsel            = sel_out.hsel;
      assign default_slv_sel = sel_out.dflt;
    end
  endgenerate

endmodule

/* hdl/ahb_master_decoder.sv */
`timescale 1ns/100ps

module ahb_master_decoder
  import ahb_pkg::*;
  import dec_map_pkg::*;
#(
  // one extra output cycle when set
  parameter bit out_reg = 1'b1
)
(
  input  logic                 hclk,
  input  logic                 hreset_n,
  input  logic                 hready,
  input  ahb_addr_phase_t      addr_phase,
  output logic [slave_num-1:0] hsel,
  output logic                 default_slv_sel
);

  // ========================================
  // internal nets
  // ========================================

  // map compare results
  logic [slave_num-1:0] hit;
  logic                 unmapped;
  logic                 page_start;
  // burst length check
  logic                 burst_over;
  // fsm to select register
  logic                 load_sel;
  logic [slave_num-1:0] load_hit;
  logic                 err_sel;

  // combinational map decode
  ahb_addr_match i_ahb_addr_match (
    .addr_phase (addr_phase),
    .hit        (hit),
    .unmapped   (unmapped),
    .page_start (page_start)
  );

  // fixed-length burst tracking
  beat_counter i_beat_counter (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .hready     (hready),
    .addr_phase (addr_phase),
    .burst_over (burst_over)
  );

  dec_fsm i_dec_fsm (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .hready     (hready),
    .addr_phase (addr_phase),
    .hit        (hit),
    .unmapped   (unmapped),
    .page_start (page_start),
    .burst_over (burst_over),
    .load_sel   (load_sel),
    .load_hit   (load_hit),
    .err_sel    (err_sel)
  );

  sel_register #(
    .out_reg (out_reg)
  ) i_sel_register (
    .hclk            (hclk),
    .hreset_n        (hreset_n),
    .load_sel        (load_sel),
    .load_hit        (load_hit),
    .err_sel         (err_sel),
    .hsel            (hsel),
    .default_slv_sel (default_slv_sel)
  );

endmodule

/* tb/dec_checker.sv */
`timescale 1ns/100ps

module dec_checker
  import ahb_pkg::*;
  import dec_map_pkg::*;
#(
  parameter bit out_reg = 1'b1
)
(
  input  logic                 hclk,
  input  logic                 hreset_n,
  input  logic                 hready,
  input  ahb_addr_phase_t      addr_phase,
  input  logic [slave_num-1:0] hsel,
  input  logic                 default_slv_sel,
  input  logic                 tbl_valid,
  input  logic [slave_num-1:0] tbl_hsel,
  input  logic                 tbl_dflt,
  output int                   model_errs,
  output int                   table_errs
);

  // ========================================
  // reference model state
  // ========================================

  dec_state_t           m_state;
  logic [slave_num-1:0] m_sel;
  logic [3:0]           m_left;
  logic                 m_unlim;
  logic                 m_over;
  logic                 m_page;
  logic [slave_num-1:0] e_hsel;
  logic                 e_dflt;
  // output stage copy, used when out_reg is set
  logic [slave_num-1:0] p_hsel;
  logic                 p_dflt;
  // table expectation, captured and delayed alongside
  logic                 t_valid_q;
  logic [slave_num-1:0] t_hsel_q;
  logic                 t_dflt_q;
  logic                 t_valid_d;
  logic [slave_num-1:0] t_hsel_d;
  logic                 t_dflt_d;
  int                   n_model;
  int                   n_table;

  // map bounds written out from the address map
  function automatic logic [slave_num-1:0] expected_slave(input logic [31:0] addr);
    logic [slave_num-1:0] sel;
    sel = '0;
    if (addr <= 32'h0000_03FF)
      sel = 3'b001;
    else if ((addr >= 32'h0000_1000) && (addr <= 32'h0000_13FF))
      sel = 3'b010;
    else if ((addr >= 32'h0000_2400) && (addr <= 32'h0000_27FF))
      sel = 3'b100;
    return sel;
  endfunction

  // beats left after the first one
  function automatic logic [3:0] burst_beats(input hburst_t kind);
    logic [3:0] beats;
    case (kind)
      WRAP4, INCR4:   beats = 4'd3;
      WRAP8, INCR8:   beats = 4'd7;
      WRAP16, INCR16: beats = 4'd15;
      default:        beats = 4'd0;
    endcase
    return beats;
  endfunction

  task automatic check_outputs(input string src, input logic [slave_num-1:0] exp_h,
                               input logic exp_d, output int fails);
    fails = 0;
    if (hsel !== exp_h)
    begin
      $display("ERROR %0t ns hsel (%s) expected %b actual %b", $time, src, exp_h, hsel);
      fails++;
    end
    if (default_slv_sel !== exp_d)
    begin
      $display("ERROR %0t ns default_slv_sel (%s) expected %b actual %b",
               $time, src, exp_d, default_slv_sel);
      fails++;
    end
  endtask

  initial
  begin
    model_errs = 0;
    table_errs = 0;
  end

  // SEQ past a fixed-length burst, or onto a 1 KB page start
  assign m_over = (m_left == 4'd0) && !m_unlim;
  assign m_page = (addr_phase.haddr.raw[9:0] == 10'd0);
  assign e_hsel = (m_state == DEC_SLVSEL) ? m_sel : '0;
  assign e_dflt = (m_state == DEC_ERROR);

  // ========================================
  // model update on each edge
  // ========================================

  always @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      m_state   <= DEC_IDLE;
      m_sel     <= '0;
      m_left    <= 4'd0;
      m_unlim   <= 1'b0;
      p_hsel    <= '0;
      p_dflt    <= 1'b0;
      t_valid_q <= 1'b0;
      t_valid_d <= 1'b0;
    end
    else
    begin
      // hready low changes nothing
      if (hready)
      begin
        case (addr_phase.htrans)
          NONSEQ:
          begin
            m_sel   <= expected_slave(addr_phase.haddr.raw);
            m_state <= (expected_slave(addr_phase.haddr.raw) != '0) ? DEC_SLVSEL : DEC_ERROR;
            m_left  <= burst_beats(addr_phase.hburst);
            m_unlim <= (addr_phase.hburst == INCR);
          end
          SEQ:
          begin
            if ((m_state != DEC_SLVSEL) || m_over || m_page)
              m_state <= DEC_ERROR;
            if (m_left != 4'd0)
              m_left <= m_left - 4'd1;
          end
          IDLE:
          begin
            m_state <= DEC_IDLE;
          end
          // BUSY holds
          default:
          begin
          end
        endcase
      end
      p_hsel    <= e_hsel;
      p_dflt    <= e_dflt;
      t_valid_q <= tbl_valid;
      t_hsel_q  <= tbl_hsel;
      t_dflt_q  <= tbl_dflt;
      t_valid_d <= t_valid_q;
      t_hsel_d  <= t_hsel_q;
      t_dflt_d  <= t_dflt_q;
    end
  end

  // ========================================
  // compare mid-cycle, outputs settled
  // ========================================

  always @(negedge hclk)
  begin
    if (hreset_n)
    begin
      if (out_reg)
      begin
        check_outputs("model", p_hsel, p_dflt, n_model);
        model_errs += n_model;
        if (t_valid_d)
        begin
          check_outputs("table", t_hsel_d, t_dflt_d, n_table);
          table_errs += n_table;
        end
      end
      else
      begin
        check_outputs("model", e_hsel, e_dflt, n_model);
        model_errs += n_model;
        if (t_valid_q)
        begin
          check_outputs("table", t_hsel_q, t_dflt_q, n_table);
          table_errs += n_table;
        end
      end
    end
  end

endmodule

/* tb/tb_ahb_master_decoder.sv */
`timescale 1ns/100ps

module tb_ahb_master_decoder
  import ahb_pkg::*;
  import dec_map_pkg::*;
();

  localparam bit          out_reg    = 1'b1;
  localparam int          rand_count = 40;
  localparam realtime     clk_period = 8.0;

  // one address phase and the outputs expected after its edge
  typedef struct packed
  {
    htrans_t              htrans;
    hburst_t              hburst;
    logic [31:0]          haddr;
    logic                 hready;
    logic [slave_num-1:0] exp_hsel;
    logic                 exp_dflt;
  } stim_row_t;

  logic                 hclk;
  logic                 hreset_n;
  logic                 hready;
  ahb_addr_phase_t      addr_phase;
  logic [slave_num-1:0] hsel;
  logic                 default_slv_sel;
  logic                 tbl_valid;
  logic [slave_num-1:0] tbl_hsel;
  logic                 tbl_dflt;
  int                   model_errs;
  int                   table_errs;
  stim_row_t            stim_rows [$];
  logic                 table_built;
  logic [31:0]          seed;

  ahb_master_decoder #(
    .out_reg (out_reg)
  ) i_ahb_master_decoder (
    .hclk            (hclk),
    .hreset_n        (hreset_n),
    .hready          (hready),
    .addr_phase      (addr_phase),
    .hsel            (hsel),
    .default_slv_sel (default_slv_sel)
  );

  dec_checker #(
    .out_reg (out_reg)
  ) i_dec_checker (
    .hclk            (hclk),
    .hreset_n        (hreset_n),
    .hready          (hready),
    .addr_phase      (addr_phase),
    .hsel            (hsel),
    .default_slv_sel (default_slv_sel),
    .tbl_valid       (tbl_valid),
    .tbl_hsel        (tbl_hsel),
    .tbl_dflt        (tbl_dflt),
    .model_errs      (model_errs),
    .table_errs      (table_errs)
  );

  // ========================================
  // helpers
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic add_row(input htrans_t t, input hburst_t b, input logic [31:0] a,
                         input logic r, input logic [slave_num-1:0] h, input logic d);
    stim_row_t row;
    row.htrans   = t;
    row.hburst   = b;
    row.haddr    = a;
    row.hready   = r;
    row.exp_hsel = h;
    row.exp_dflt = d;
    stim_rows.push_back(row);
  endtask

  task automatic drive_phase(input htrans_t t, input hburst_t b, input logic [31:0] a,
                             input logic r);
    addr_phase.htrans    = t;
    addr_phase.hburst    = b;
    addr_phase.hsize     = WORD;
    addr_phase.haddr.raw = a;
    hready               = r;
  endtask

  // inputs change 1 ns after the edge
  task automatic next_cycle();
    @(posedge hclk);
    #1;
  endtask

  task automatic build_table();
    // singles on each region and its bounds
    add_row(NONSEQ, SINGLE, 32'h0000_0000, 1'b1, 3'b001, 1'b0);
    add_row(NONSEQ, SINGLE, 32'h0000_03FF, 1'b1, 3'b001, 1'b0);
    add_row(NONSEQ, SINGLE, 32'h0000_1000, 1'b1, 3'b010, 1'b0);
    add_row(NONSEQ, SINGLE, 32'h0000_13FF, 1'b1, 3'b010, 1'b0);
    add_row(NONSEQ, SINGLE, 32'h0000_2400, 1'b1, 3'b100, 1'b0);
    add_row(NONSEQ, SINGLE, 32'h0000_27FF, 1'b1, 3'b100, 1'b0);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    // unmapped address holds the default slave over SEQ until IDLE
    add_row(NONSEQ, SINGLE, 32'h0000_0800, 1'b1, 3'b000, 1'b1);
    add_row(SEQ,    SINGLE, 32'h0000_0804, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    add_row(NONSEQ, INCR,   32'h0000_2000, 1'b1, 3'b000, 1'b1);
    add_row(SEQ,    INCR,   32'h0000_2004, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    add_row(NONSEQ, SINGLE, 32'h0000_3000, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    // fifth beat of an INCR4 overruns
    add_row(NONSEQ, INCR4,  32'h0000_1000, 1'b1, 3'b010, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_1004, 1'b1, 3'b010, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_1008, 1'b1, 3'b010, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_100C, 1'b1, 3'b010, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_1010, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    // INCR running onto a 1 KB page start
    add_row(NONSEQ, INCR,   32'h0000_03F8, 1'b1, 3'b001, 1'b0);
    add_row(SEQ,    INCR,   32'h0000_03FC, 1'b1, 3'b001, 1'b0);
    add_row(SEQ,    INCR,   32'h0000_0400, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    // wait states and BUSY mid-burst hold the select and the beat count
    // all three SEQ beats of the INCR4 must still fit
    add_row(NONSEQ, INCR4,  32'h0000_2400, 1'b1, 3'b100, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_2404, 1'b0, 3'b100, 1'b0);
    add_row(BUSY,   INCR4,  32'h0000_2404, 1'b1, 3'b100, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_2404, 1'b1, 3'b100, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_2408, 1'b0, 3'b100, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_2408, 1'b1, 3'b100, 1'b0);
    add_row(SEQ,    INCR4,  32'h0000_240C, 1'b1, 3'b100, 1'b0);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b0, 3'b100, 1'b0);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    // error select holds on a wait state too
    add_row(NONSEQ, SINGLE, 32'h0000_3000, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b0, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
    // SEQ with no burst open selects the default slave
    add_row(SEQ,    INCR,   32'h0000_1004, 1'b1, 3'b000, 1'b1);
    add_row(IDLE,   SINGLE, 32'h0000_0000, 1'b1, 3'b000, 1'b0);
  endtask

  // ========================================
  // clock, watchdog, stimulus
  // ========================================

  initial
  begin
    hclk = 1'b0;
    forever #(clk_period / 2.0) hclk = ~hclk;
  end

  // budget covers the table rows, a single plus an IDLE per random transfer and some slack
  initial
  begin
    wait (table_built === 1'b1);
    #((stim_rows.size() + 2 * rand_count + 20) * clk_period);
    $display("timeout, the stimulus did not finish in its cycle budget");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    table_built = 1'b0;
    hreset_n    = 1'b0;
    hready      = 1'b0;
    addr_phase  = '0;
    tbl_valid   = 1'b0;
    tbl_hsel    = '0;
    tbl_dflt    = 1'b0;
    build_table();
    table_built = 1'b1;
    repeat (3) @(posedge hclk);
    #1;
    hreset_n = 1'b1;
    foreach (stim_rows[i])
    begin
      drive_phase(stim_rows[i].htrans, stim_rows[i].hburst, stim_rows[i].haddr,
                  stim_rows[i].hready);
      tbl_valid = 1'b1;
      tbl_hsel  = stim_rows[i].exp_hsel;
      tbl_dflt  = stim_rows[i].exp_dflt;
      next_cycle();
    end
    tbl_valid = 1'b0;
    // random singles each followed by an IDLE
    seed = 32'd97;
    repeat (rand_count)
    begin
      seed = xorshift32(seed);
      drive_phase(NONSEQ, SINGLE, seed % 32'h0000_3000, 1'b1);
      next_cycle();
      drive_phase(IDLE, SINGLE, 32'h0000_0000, 1'b1);
      next_cycle();
    end
    // let the output stage drain
    repeat (int'(out_reg) + 2) next_cycle();
    $display("errors: model %0d, table %0d", model_errs, table_errs);
    if ((model_errs == 0) && (table_errs == 0))
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* all.f */
hdl/ahb_pkg.sv
hdl/dec_map_pkg.sv
hdl/ahb_addr_match.sv
hdl/beat_counter.sv
hdl/dec_fsm.sv
hdl/sel_register.sv
hdl/ahb_master_decoder.sv
tb/dec_checker.sv
tb/tb_ahb_master_decoder.sv

/* Bender.yml */
package:
  name: ahb_master_decoder

sources:
  - hdl/ahb_pkg.sv
  - hdl/dec_map_pkg.sv
  - hdl/ahb_addr_match.sv
  - hdl/beat_counter.sv
  - hdl/dec_fsm.sv
  - hdl/sel_register.sv
  - hdl/ahb_master_decoder.sv
  - target: test
    files:
      - tb/dec_checker.sv
      - tb/tb_ahb_master_decoder.sv
